//--- logic/dmm_config.svh
// dmm front end constants

`ifndef DMM_CONFIG_SVH
`define DMM_CONFIG_SVH

// system clock, all timing below counts these cycles
`define DMM_CLK_FREQ          20000000

// precharge pause after reset, 500 us
`define DMM_PRECHARGE_DEFAULT (`DMM_CLK_FREQ / 2000)

// integration window in clocks
// count is 16 bits so keep this at or below 65535, and above zero
// short window for simulation
`define DMM_INTEG_CLKS        64

// sample queue entries, power of two so the pointers wrap by themselves
`define DMM_QUEUE_DEPTH       8

`endif

//--- logic/dmm_pkg.sv
// dmm front end types

package dmm_pkg;

  //////////////////////////////////////////////////////////////////////
  // sample record
  //////////////////////////////////////////////////////////////////////

  // one conversion result as it sits in the queue
  // packed seq high, count low, the same layout as the data register
  typedef struct packed {
    // conversion sequence number, wraps at 255
    logic [7:0]  seq;
    // comparator-high cycles in the integration window
    logic [15:0] count;
  } sample_t;

  //////////////////////////////////////////////////////////////////////
  // sequencer phases
  //////////////////////////////////////////////////////////////////////

  // idle until run, then precharge pause, start pulse, wait for adc
  typedef enum logic [2:0] {
    ph_idle,
    ph_precharge_load,
    ph_precharge_wait,
    ph_start,
    ph_await
  } seq_phase_t;

endpackage

//--- logic/modulation_no_az.sv
// precharge and conversion sequencer

`timescale 1ns/1ps

module modulation_no_az
(
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  input  logic [23:0] precharge_clks,
  input  logic        adc_measure_ready,
  output logic        adc_measure_start,
  output logic        led0,
  output logic        precharge_active
);

  import dmm_pkg::*;

  // current phase of the loop
  seq_phase_t  phase;

  // precharge timer, wider than the register for timing slack
  logic [31:0] count_down;

  //////////////////////////////////////////////////////////////////////
  // phase decode
  //////////////////////////////////////////////////////////////////////

  // input is protected for the whole wait phase
  assign precharge_active  = (phase == ph_precharge_wait);

  // start phase is one cycle long, so this is the start pulse
  assign adc_measure_start = (phase == ph_start);

  //////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      phase      <= ph_idle;
      count_down <= '0;
      led0       <= 1'b0;
    end
    else
    begin
      case (phase)

        // parked until the host sets run
        ph_idle:
        begin
          if (run)
            phase <= ph_precharge_load;
        end

        // arm the pause timer from the host register
        ph_precharge_load:
        begin
          count_down <= {8'b0, precharge_clks};
          phase      <= ph_precharge_wait;
        end

        // stay here precharge_clks cycles
        // a zero length still spends one cycle here
        ph_precharge_wait:
        begin
          count_down <= count_down - 32'd1;
          if (count_down <= 32'd1)
            phase <= ph_start;
        end

        // one cycle, kicks the conversion
        ph_start:
        begin
          // blink on every conversion
          led0  <= ~led0;
          phase <= ph_await;
        end

        // no new start until the adc reports back
        ph_await:
        begin
          if (adc_measure_ready)
          begin
            // loop again only while run is still set
            if (run)
              phase <= ph_precharge_load;
            else
              phase <= ph_idle;
          end
        end

        default:
          phase <= ph_idle;

      endcase
    end
  end

endmodule

//--- logic/adc_conversion.sv
// charge balance conversion stage

`timescale 1ns/1ps

`include "dmm_config.svh"

module adc_conversion
(
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic             comp,
  output logic             ready,
  output logic             busy,
  output dmm_pkg::sample_t sample
);

  // integration window length
  localparam int unsigned integ_clks = `DMM_INTEG_CLKS;

  // cycles left in the window
  logic [15:0] remaining;
  // comparator ones so far
  logic [15:0] acc;
  // number given to the next result
  logic [7:0]  seq;
  // last sampling edge of the window
  logic        last_edge;

  assign last_edge = busy && (remaining == 16'd1);

  //////////////////////////////////////////////////////////////////////
  // window control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy      <= 1'b0;
      ready     <= 1'b0;
      remaining <= '0;
      seq       <= '0;
    end
    else
    begin
      // ready is a single cycle pulse
      ready <= 1'b0;
      if (busy)
      begin
        remaining <= remaining - 16'd1;
        if (last_edge)
        begin
          busy  <= 1'b0;
          ready <= 1'b1;
          seq   <= seq + 8'd1;
        end
      end
      // a start during a conversion is ignored
      else if (start)
      begin
        busy      <= 1'b1;
        remaining <= 16'(integ_clks);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // accumulator and result
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    // comp is sampled on every edge while busy
    if (start && !busy)
      acc <= '0;
    else if (busy)
      acc <= acc + {15'b0, comp};

    // result holds until the next window closes
    if (last_edge)
    begin
      sample.count <= acc + {15'b0, comp};
      sample.seq   <= seq;
    end
  end

endmodule

//--- logic/sample_queue.sv
// sample record FIFO

`timescale 1ns/1ps

`include "dmm_config.svh"

module sample_queue
(
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  dmm_pkg::sample_t din,
  input  logic             pop,
  input  logic             clear_overflow,
  output dmm_pkg::sample_t dout,
  output logic [3:0]       level,
  output logic             overflow
);

  import dmm_pkg::*;

  localparam int depth = `DMM_QUEUE_DEPTH;
  localparam int ptr_w = $clog2(depth);

  // record storage
  sample_t          mem [depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic             full;
  logic             empty;
  logic             do_push;
  logic             do_pop;

  assign full    = (level == 4'(depth));
  assign empty   = (level == 4'd0);
  // pipeline never stalls so a push into a full queue is lost
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // head is always visible
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      level    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + ptr_w'(1);
      if (do_pop)
        rd_ptr <= rd_ptr + ptr_w'(1);

      if (do_push && !do_pop)
        level <= level + 4'd1;
      else if (do_pop && !do_push)
        level <= level - 4'd1;

      // sticky until the host clears it and a new drop wins
      if (push && full)
        overflow <= 1'b1;
      else if (clear_overflow)
        overflow <= 1'b0;
    end
  end

endmodule

//--- logic/wb_readout.sv
// wishbone register block

`timescale 1ns/1ps

`include "dmm_config.svh"

module wb_readout
(
  input  logic             clk,
  input  logic             reset,

  // wishbone classic slave
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  logic [1:0]       adr,
  input  logic [31:0]      dat_w,
  output logic [31:0]      dat_r,
  output logic             ack,

  // sequencer control
  output logic             run,
  output logic [23:0]      precharge_clks,

  // queue side
  input  logic [3:0]       level,
  input  logic             overflow,
  input  dmm_pkg::sample_t head,
  output logic             pop,
  output logic             clear_overflow
);

  // transfer being acked at the next edge
  logic        access;
  // read data before the output register
  logic [31:0] rd_mux;

  // ack low in the access cycle keeps each ack to one cycle
  assign access = cyc && stb && !ack;

  //////////////////////////////////////////////////////////////////////
  // side effects
  //////////////////////////////////////////////////////////////////////

  // data read pops the head, nothing to pop when empty
  assign pop            = access && !we && (adr == 2'd3) && (level != 4'd0);
  // any write to status clears the drop flag
  assign clear_overflow = access && we && (adr == 2'd2);

  //////////////////////////////////////////////////////////////////////
  // control registers and ack
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ack            <= 1'b0;
      run            <= 1'b0;
      precharge_clks <= 24'(`DMM_PRECHARGE_DEFAULT);
    end
    else
    begin
      ack <= access;
      if (access && we)
      begin
        if (adr == 2'd0)
          run <= dat_w[0];
        else if (adr == 2'd1)
          precharge_clks <= dat_w[23:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (adr)
      2'd0:    rd_mux = {31'b0, run};
      2'd1:    rd_mux = {8'b0, precharge_clks};
      // level in 3:0, overflow in 8
      2'd2:    rd_mux = {23'b0, overflow, 4'b0, level};
      // empty queue reads as zero
      default: rd_mux = (level != 4'd0) ? {8'b0, head.seq, head.count} : 32'b0;
    endcase
  end

  // valid while ack is high
  always_ff @(posedge clk)
  begin
    if (access && !we)
      dat_r <= rd_mux;
  end

endmodule

//--- logic/dmm_frontend_top.sv
// dmm measurement front end

`timescale 1ns/1ps

module dmm_frontend_top
(
  input  logic        clk,
  input  logic        reset,
  input  logic        comp,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [1:0]  adr,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack,
  output logic        led0,
  output logic [1:0]  monitor
);

  import dmm_pkg::*;

  // sequencer to conversion
  logic        adc_measure_start;
  logic        adc_measure_ready;
  sample_t     sample;

  // queue to bus block
  sample_t     queue_head;
  logic [3:0]  queue_level;
  logic        queue_overflow;
  logic        queue_pop;
  logic        clear_overflow;

  // bus block to sequencer
  logic        run;
  logic [23:0] precharge_clks;

  //////////////////////////////////////////////////////////////////////
  // pipeline
  //////////////////////////////////////////////////////////////////////

  // monitor 0 shows the precharge pause
  modulation_no_az i_modulation_no_az (
    .clk               (clk),
    .reset             (reset),
    .run               (run),
    .precharge_clks    (precharge_clks),
    .adc_measure_ready (adc_measure_ready),
    .adc_measure_start (adc_measure_start),
    .led0              (led0),
    .precharge_active  (monitor[0])
  );

  // monitor 1 shows the integration window
  adc_conversion i_adc_conversion (
    .clk    (clk),
    .reset  (reset),
    .start  (adc_measure_start),
    .comp   (comp),
    .ready  (adc_measure_ready),
    .busy   (monitor[1]),
    .sample (sample)
  );

  // ready doubles as the push strobe
  sample_queue i_sample_queue (
    .clk            (clk),
    .reset          (reset),
    .push           (adc_measure_ready),
    .din            (sample),
    .pop            (queue_pop),
    .clear_overflow (clear_overflow),
    .dout           (queue_head),
    .level          (queue_level),
    .overflow       (queue_overflow)
  );

  //////////////////////////////////////////////////////////////////////
  // host access
  //////////////////////////////////////////////////////////////////////

  wb_readout i_wb_readout (
    .clk            (clk),
    .reset          (reset),
    .cyc            (cyc),
    .stb            (stb),
    .we             (we),
    .adr            (adr),
    .dat_w          (dat_w),
    .dat_r          (dat_r),
    .ack            (ack),
    .run            (run),
    .precharge_clks (precharge_clks),
    .level          (queue_level),
    .overflow       (queue_overflow),
    .head           (queue_head),
    .pop            (queue_pop),
    .clear_overflow (clear_overflow)
  );

endmodule

//--- verification/dmm_frontend_chk.sv
// handshake assertions

`timescale 1ns/1ps

module dmm_frontend_chk
(
  input logic       clk,
  input logic       reset,
  input logic       cyc,
  input logic       stb,
  input logic       we,
  input logic [1:0] adr,
  input logic       ack,
  input logic       start,
  input logic       busy,
  input logic       ready,
  input logic       overflow
);

  //////////////////////////////////////////////////////////////////////
  // bus
  //////////////////////////////////////////////////////////////////////

  ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
    else $error("ack held for more than one cycle");

  //////////////////////////////////////////////////////////////////////
  // sequencer and conversion
  //////////////////////////////////////////////////////////////////////

  start_idle: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
    else $error("start issued during a conversion");

  ready_single: assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
    else $error("ready held for more than one cycle");

  // ready comes in the cycle right after busy drops
  ready_after_busy: assert property (@(posedge clk) disable iff (reset)
    ready |-> (!busy && $past(busy)))
    else $error("ready without busy falling");

  busy_then_ready: assert property (@(posedge clk) disable iff (reset)
    $fell(busy) |-> ready)
    else $error("busy fell without ready");

  //////////////////////////////////////////////////////////////////////
  // queue
  //////////////////////////////////////////////////////////////////////

  // sticky flag, only an acked status write clears it
  overflow_sticky: assert property (@(posedge clk) disable iff (reset)
    $fell(overflow) |-> (ack && $past(cyc && stb && we && (adr == 2'd2))))
    else $error("overflow cleared without a status write");

endmodule

bind dmm_frontend_top dmm_frontend_chk i_dmm_frontend_chk (
  .clk      (clk),
  .reset    (reset),
  .cyc      (cyc),
  .stb      (stb),
  .we       (we),
  .adr      (adr),
  .ack      (ack),
  .start    (adc_measure_start),
  .busy     (monitor[1]),
  .ready    (adc_measure_ready),
  .overflow (queue_overflow)
);

//--- verification/dmm_frontend_tb.sv
// dmm front end testbench

`timescale 1ns/1ps

`include "dmm_config.svh"

module dmm_frontend_tb;

  import dmm_pkg::*;

  localparam int depth        = `DMM_QUEUE_DEPTH;
  localparam int wait_limit   = 5000;
  localparam int ack_limit    = 20;

  logic        clk = 1'b0;
  logic        reset;
  logic        comp;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [1:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;
  logic        led0;
  logic [1:0]  monitor;

  // lfsr states for the comp stream and the bus stimulus
  logic [31:0] comp_state;
  logic [31:0] stim_state;

  // reference model state written only by the model block
  logic [31:0] hist[$];
  logic [15:0] model_acc = '0;
  logic [7:0]  model_seq = '0;
  logic        in_window = 1'b0;
  int          closed = 0;
  int          opened = 0;
  int          win_len = 0;
  int          drop_total = 0;
  int          edge_drops_before = 0;
  int          edge_level = 0;
  int          pc_len = 0;
  int          pc_count = 0;

  // host side view written only by the main process
  int          rd_idx;
  int          drop_seen;
  logic        pc_check;
  int          pc_expect;

  always #20 clk = ~clk;

  dmm_frontend_top i_dmm_frontend_top (
    .clk     (clk),
    .reset   (reset),
    .comp    (comp),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .dat_w   (dat_w),
    .dat_r   (dat_r),
    .ack     (ack),
    .led0    (led0),
    .monitor (monitor)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      stim_state = lfsr_step(stim_state);
      v = {v[30:0], stim_state[0]};
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and model
  //////////////////////////////////////////////////////////////////////

  // one comparator bit per cycle
  initial
  begin
    comp       = 1'b0;
    comp_state = 32'h40a7;
    forever
    begin
      @(posedge clk);
      #2;
      comp_state = lfsr_step(comp_state);
      comp = comp_state[0];
    end
  end

  // sees the values from before each edge as the flops do
  always @(posedge clk)
  begin
    edge_level        = hist.size() - rd_idx;
    edge_drops_before = drop_total;
    if (monitor[1])
    begin
      // first edge of a new window where led0 has already toggled
      if (!in_window)
        opened++;
      model_acc = model_acc + {15'b0, comp};
      win_len++;
      in_window = 1'b1;
    end
    else if (in_window)
    begin
      // busy fell last edge so ready is up and the push lands on this edge
      check_value("monitor[1] cycles", 32'(win_len), 32'(`DMM_INTEG_CLKS));
      if (edge_level < depth)
        hist.push_back({8'b0, model_seq, model_acc});
      else
        drop_total++;
      model_seq = model_seq + 8'd1;
      model_acc = '0;
      win_len   = 0;
      in_window = 1'b0;
      closed++;
    end
    // led0 toggles once per conversion
    if (!reset)
      check_value("led0", 32'(led0), 32'(opened % 2));
    // length of each precharge pause
    if (monitor[0])
      pc_len++;
    else
    begin
      if (pc_check && pc_len != 0)
      begin
        check_value("monitor[0] cycles", 32'(pc_len), 32'(pc_expect));
        pc_count++;
      end
      pc_len = 0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // wishbone master
  //////////////////////////////////////////////////////////////////////

  task automatic bus_access(input logic write, input logic [1:0] a,
                            input logic [31:0] wd, output logic [31:0] rd);
    int n;
    n = 0;
    @(posedge clk);
    #2;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    dat_w = wd;
    @(posedge clk);
    #1;
    while (!ack)
    begin
      n++;
      if (n > ack_limit)
        abort_run("bus access was never acknowledged");
      @(posedge clk);
      #1;
    end
    rd = dat_r;
    // master drops stb right after ack
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic bus_write(input logic [1:0] a, input logic [31:0] d);
    logic [31:0] unused_rd;
    bus_access(1'b1, a, d, unused_rd);
    // clear wins over older drops but not over one on the same edge
    if (a == 2'd2)
      drop_seen = edge_drops_before;
  endtask

  task automatic bus_read(input logic [1:0] a, output logic [31:0] d);
    bus_access(1'b0, a, 32'h0, d);
  endtask

  // level at the acked edge decides whether a record pops
  task automatic read_data_checked(output logic [31:0] d, output logic popped);
    logic [31:0] exp;
    bus_read(2'd3, d);
    popped = (edge_level != 0);
    if (popped)
    begin
      exp = hist[rd_idx];
      rd_idx++;
    end
    else
      exp = 32'h0;
    check_value("data", d, exp);
  endtask

  task automatic read_status_checked(output logic [31:0] d);
    logic [31:0] exp;
    bus_read(2'd2, d);
    exp = {23'b0, (edge_drops_before != drop_seen), 4'b0, 4'(edge_level)};
    check_value("status", d, exp);
  endtask

  task automatic wait_conversions(input int target, input string what);
    int n;
    n = 0;
    while (closed < target)
    begin
      n++;
      if (n > wait_limit)
        abort_run($sformatf("timed out waiting for %s", what));
      @(posedge clk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin : main
    logic [31:0] d;
    logic [31:0] r;
    logic        popped;
    int          n;
    int          got;
    int          quiet;
    int          start_closed;
    int          last_seq;
    reset      = 1'b1;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = 2'd0;
    dat_w      = 32'h0;
    rd_idx     = 0;
    drop_seen  = 0;
    pc_check   = 1'b0;
    pc_expect  = 0;
    // same seed stepped away from the comp stream
    stim_state = 32'h40a7;
    for (int i = 0; i < 64; i++)
      stim_state = lfsr_step(stim_state);
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    // registers straight after reset
    bus_read(2'd2, d);
    check_value("status", d, 32'h0);
    read_data_checked(d, popped);
    check_value("data", d, 32'h0);
    bus_read(2'd1, d);
    check_value("precharge_clks", d, 32'(`DMM_PRECHARGE_DEFAULT));
    bus_read(2'd0, d);
    check_value("control", d, 32'h0);

    // precharge register readback
    for (int i = 0; i < 8; i++)
    begin
      random_bits(24, r);
      bus_write(2'd1, r);
      bus_read(2'd1, d);
      check_value("precharge_clks", d, r);
    end

    // short pause of 3 to 10 cycles watched by the model block
    random_bits(3, r);
    pc_expect = 3 + int'(r);
    bus_write(2'd1, 32'(pc_expect));
    pc_check = 1'b1;
    bus_write(2'd0, 32'h1);
    wait_conversions(3, "first conversions");
    if (pc_count < 3)
      abort_run("no precharge pause was seen before the first conversions");

    // frequent polling so nothing may be dropped
    got      = 0;
    last_seq = -1;
    n        = 0;
    while (got < 12)
    begin
      n++;
      if (n > wait_limit)
        abort_run("timed out polling the queue");
      random_bits(2, r);
      repeat (int'(r)) @(posedge clk);
      read_data_checked(d, popped);
      if (popped)
      begin
        if (last_seq >= 0)
          check_value("seq", {24'b0, d[23:16]}, 32'((last_seq + 1) % 256));
        last_seq = int'(d[23:16]);
        got++;
      end
    end

    // no reads until the queue has overflowed
    start_closed = closed;
    wait_conversions(start_closed + depth + 3, "queue overflow");
    read_status_checked(d);
    check_value("status level", 32'(d[3:0]), 32'(depth));
    check_value("status overflow", 32'(d[8]), 32'h1);
    for (int i = 0; i < depth; i++)
    begin
      read_data_checked(d, popped);
      check_value("pop taken", 32'(popped), 32'h1);
    end
    bus_write(2'd2, 32'h0);
    read_status_checked(d);
    check_value("status overflow", 32'(d[8]), 32'h0);

    // stop the loop and let it go quiet
    bus_write(2'd0, 32'h0);
    start_closed = closed;
    quiet = 0;
    n     = 0;
    while (quiet < 16)
    begin
      n++;
      if (n > wait_limit)
        abort_run("loop did not stop after run was cleared");
      @(posedge clk);
      #1;
      if (monitor == 2'b00)
        quiet++;
      else
        quiet = 0;
    end
    if (closed - start_closed > 1)
      abort_run("more than one record arrived after run was cleared");
    start_closed = closed;
    repeat (200)
    begin
      @(posedge clk);
      #1;
      check_value("monitor", 32'(monitor), 32'h0);
    end
    if (closed != start_closed)
      abort_run("a conversion ran after the loop had stopped");

    // drain and then check that an empty read changes nothing
    n = 0;
    while (hist.size() - rd_idx > 0)
    begin
      n++;
      if (n > 2 * depth)
        abort_run("queue did not drain");
      read_data_checked(d, popped);
    end
    read_data_checked(d, popped);
    check_value("data", d, 32'h0);
    read_status_checked(d);
    check_value("status level", 32'(d[3:0]), 32'h0);

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+logic
logic/dmm_pkg.sv
logic/modulation_no_az.sv
logic/adc_conversion.sv
logic/sample_queue.sv
logic/wb_readout.sv
logic/dmm_frontend_top.sv
verification/dmm_frontend_chk.sv
verification/dmm_frontend_tb.sv

//--- run_verilator.sh
#!/bin/sh
# compile and run the dmm front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module dmm_frontend_tb \
  -Mdir obj_dir \
  -o dmm_frontend_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/dmm_frontend_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
